// ==== logic/serial_pkg.sv ====
package serial_pkg;

   // RV32 fixes these widths
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;     // counts 32 bit slots
   localparam int RA_W  = 5;     // register address width

   // major opcodes handled by the unit
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   // request as seen on the port
   typedef struct packed {
      logic [XLEN-1:0] instr;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
   } exec_req_t;

   // writeback for the register file
   typedef struct packed {
      logic [RA_W-1:0] rd_addr;
      logic            rd_we;
      logic [XLEN-1:0] result;
   } exec_rsp_t;

   // operation the serial ALU performs
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_SLT  = 3'd5,
      ALU_SLTU = 3'd6
   } alu_op_e;

   // control word from decoder to ALU
   typedef struct packed {
      alu_op_e         op;
      logic            b_imm;     // b from immediate stream
      logic            a_zero;    // a forced low, LUI
      logic [RA_W-1:0] rd_addr;
      logic            rd_we;
   } alu_ctrl_t;

   // decoder run sequence
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RUN  = 2'd1,
      DONE = 2'd2
   } run_state_e;

endpackage

// ==== logic/serial_decode.sv ====
`timescale 1ns/1ps

module serial_decode (
   input  logic                       clk,
   input  logic                       i_rst,
   input  logic                       i_req,
   input  logic [serial_pkg::XLEN-1:0] i_instr,
   output logic                       o_ack,
   output logic                       o_start,
   output logic                       o_cnt_en,
   output logic                       o_cnt_first,
   output logic                       o_cnt_last,
   output logic                       o_imm_bit,
   output serial_pkg::alu_ctrl_t      o_ctrl
);

   import serial_pkg::*;

   run_state_e       state_q;
   logic [CNT_W-1:0] cnt_q;
   logic             start_q;
   logic             ack_q;

   // fields held for the whole run
   logic [6:0]       opcode_q;
   logic [2:0]       funct3_q;
   logic             f7_b30_q;
   logic [RA_W-1:0]  rd_q;
   logic [XLEN-1:0]  imm_q;

   logic             accept;
   logic [XLEN-1:0]  imm_d;
   logic             is_op;
   logic             is_opimm;
   logic             is_lui;
   logic             f3_ok;

   assign accept = (state_q == IDLE) & i_req;

   // U-type for LUI, otherwise sign extended I-type
   always_comb begin
      if (i_instr[6:0] == OPC_LUI) begin
         imm_d = {i_instr[31:12], 12'b0};
      end else begin
         imm_d = {{20{i_instr[31]}}, i_instr[31:20]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q <= IDLE;
         cnt_q   <= '0;
         start_q <= 1'b0;
         ack_q   <= 1'b0;
      end else begin
         start_q <= 1'b0;   // single cycle pulse
         case (state_q)
            IDLE: begin
               if (i_req) begin
                  state_q <= RUN;
                  start_q <= 1'b1;
                  cnt_q   <= '0;
               end
            end
            RUN: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == '1) begin
                  state_q <= DONE;   // last bit consumed this edge
               end
            end
            DONE: begin
               if (!ack_q) begin
                  ack_q <= 1'b1;     // ALU response is registered by now
               end else if (!i_req) begin
                  ack_q   <= 1'b0;
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // instruction fields and the immediate rotator
   always_ff @(posedge clk) begin
      if (accept) begin
         opcode_q <= i_instr[6:0];
         funct3_q <= i_instr[14:12];
         f7_b30_q <= i_instr[30];
         rd_q     <= i_instr[11:7];
         imm_q    <= imm_d;
      end else if (o_cnt_en) begin
         imm_q <= {imm_q[0], imm_q[XLEN-1:1]};   // lsb first
      end
   end

   assign o_ack       = ack_q;
   assign o_start     = start_q;
   assign o_cnt_en    = (state_q == RUN);
   assign o_cnt_first = o_cnt_en & (cnt_q == '0);
   assign o_cnt_last  = o_cnt_en & (cnt_q == '1);
   assign o_imm_bit   = imm_q[0];

   assign is_op    = (opcode_q == OPC_OP);
   assign is_opimm = (opcode_q == OPC_OP_IMM);
   assign is_lui   = (opcode_q == OPC_LUI);

   always_comb begin
      o_ctrl = '0;
      o_ctrl.op = ALU_ADD;
      f3_ok = 1'b1;
      case (funct3_q)
         3'b000: o_ctrl.op = (is_op & f7_b30_q) ? ALU_SUB : ALU_ADD;
         3'b010: o_ctrl.op = ALU_SLT;
         3'b011: o_ctrl.op = ALU_SLTU;
         3'b100: o_ctrl.op = ALU_XOR;
         3'b110: o_ctrl.op = ALU_OR;
         3'b111: o_ctrl.op = ALU_AND;
         default: f3_ok = 1'b0;   // shifts not handled
      endcase
      if (is_lui) begin
         o_ctrl.op     = ALU_ADD;   // 0 + imm
         o_ctrl.a_zero = 1'b1;
      end
      o_ctrl.b_imm   = is_opimm | is_lui;
      o_ctrl.rd_addr = rd_q;
      o_ctrl.rd_we   = (((is_op | is_opimm) & f3_ok) | is_lui) & (rd_q != '0);
   end

endmodule

// ==== logic/operand_shifter.sv ====
`timescale 1ns/1ps

module operand_shifter (
   input  logic                        clk,
   input  logic                        i_rst,
   input  logic                        i_start,
   input  logic                        i_cnt_en,
   input  logic [serial_pkg::XLEN-1:0] i_rs1,
   input  logic [serial_pkg::XLEN-1:0] i_rs2,
   output logic                        o_rs1_bit,
   output logic                        o_rs2_bit
);

   import serial_pkg::*;

   logic [XLEN-1:0] rs1_q;
   logic [XLEN-1:0] rs2_q;

   // start coincides with run cycle 0, so bit 0 comes straight from the input
   // and the registers load the remaining bits already shifted by one
   always_ff @(posedge clk) begin
      if (i_rst) begin
         rs1_q <= '0;
         rs2_q <= '0;
      end else if (i_start) begin
         rs1_q <= {1'b0, i_rs1[XLEN-1:1]};
         rs2_q <= {1'b0, i_rs2[XLEN-1:1]};
      end else if (i_cnt_en) begin
         rs1_q <= {1'b0, rs1_q[XLEN-1:1]};   // next bit down
         rs2_q <= {1'b0, rs2_q[XLEN-1:1]};
      end
   end

   assign o_rs1_bit = i_start ? i_rs1[0] : rs1_q[0];
   assign o_rs2_bit = i_start ? i_rs2[0] : rs2_q[0];

endmodule

// ==== logic/serial_alu.sv ====
`timescale 1ns/1ps

module serial_alu (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_start,
   input  logic                  i_cnt_en,
   input  logic                  i_cnt_first,
   input  logic                  i_cnt_last,
   input  serial_pkg::alu_ctrl_t i_ctrl,
   input  logic                  i_rs1_bit,
   input  logic                  i_rs2_bit,
   input  logic                  i_imm_bit,
   output serial_pkg::exec_rsp_t o_rsp
);

   import serial_pkg::*;

   logic            a_bit;
   logic            b_raw;
   logic            b_bit;
   logic            sub_like;
   logic            is_cmp;
   logic            c_in;
   logic            sum;
   logic            c_out;
   logic            res_bit;
   logic            lt;
   logic [XLEN-1:0] res_q;
   logic            carry_q;
   logic            lt_q;
   logic            done_q;
   logic [XLEN-1:0] result;

   assign a_bit    = i_ctrl.a_zero ? 1'b0 : i_rs1_bit;
   assign b_raw    = i_ctrl.b_imm ? i_imm_bit : i_rs2_bit;
   assign is_cmp   = (i_ctrl.op == ALU_SLT) | (i_ctrl.op == ALU_SLTU);
   assign sub_like = (i_ctrl.op == ALU_SUB) | is_cmp;

   // a + ~b + 1 for subtract and compare
   assign b_bit = b_raw ^ sub_like;
   assign c_in  = i_cnt_first ? sub_like : carry_q;
   assign sum   = a_bit ^ b_bit ^ c_in;
   assign c_out = (a_bit & b_bit) | (a_bit & c_in) | (b_bit & c_in);

   always_comb begin
      case (i_ctrl.op)
         ALU_ADD, ALU_SUB: res_bit = sum;
         ALU_AND:          res_bit = a_bit & b_raw;
         ALU_OR:           res_bit = a_bit | b_raw;
         ALU_XOR:          res_bit = a_bit ^ b_raw;
         default:          res_bit = 1'b0;   // compare fills in later
      endcase
   end

   // valid on the sign bit only
   // unsigned borrow is the missing carry out
   // signed uses a's sign when the signs differ, else the difference sign
   always_comb begin
      if (i_ctrl.op == ALU_SLTU) begin
         lt = ~c_out;
      end else if (a_bit ^ b_raw) begin
         lt = a_bit;
      end else begin
         lt = sum;
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= c_out;
         res_q   <= {res_bit, res_q[XLEN-1:1]};   // enters from the top
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         lt_q   <= 1'b0;
         done_q <= 1'b0;
      end else begin
         done_q <= i_cnt_last;
         if (i_start) begin
            lt_q <= 1'b0;
         end else if (i_cnt_last) begin
            lt_q <= lt;
         end
      end
   end

   // unsupported or rd zero gives a zero result
   always_comb begin
      if (!i_ctrl.rd_we) begin
         result = '0;
      end else if (is_cmp) begin
         result = {{(XLEN-1){1'b0}}, lt_q};
      end else begin
         result = res_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_rsp <= '0;
      end else if (done_q) begin
         o_rsp.rd_addr <= i_ctrl.rd_addr;
         o_rsp.rd_we   <= i_ctrl.rd_we;
         o_rsp.result  <= result;
      end
   end

endmodule

// ==== logic/serial_exec_top.sv ====
`timescale 1ns/1ps

module serial_exec_top (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_req,
   input  serial_pkg::exec_req_t i_req_data,
   output logic                  o_ack,
   output serial_pkg::exec_rsp_t o_rsp
);

   import serial_pkg::*;

   logic      start;
   logic      cnt_en;
   logic      cnt_first;
   logic      cnt_last;
   logic      imm_bit;
   logic      rs1_bit;
   logic      rs2_bit;
   alu_ctrl_t ctrl;

   serial_decode u_decode (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_req       (i_req),
      .i_instr     (i_req_data.instr),
      .o_ack       (o_ack),
      .o_start     (start),
      .o_cnt_en    (cnt_en),
      .o_cnt_first (cnt_first),
      .o_cnt_last  (cnt_last),
      .o_imm_bit   (imm_bit),
      .o_ctrl      (ctrl)
   );

   // register operands, same pace as the immediate
   operand_shifter u_shifter (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_start   (start),
      .i_cnt_en  (cnt_en),
      .i_rs1     (i_req_data.rs1),
      .i_rs2     (i_req_data.rs2),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu u_alu (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_start     (start),
      .i_cnt_en    (cnt_en),
      .i_cnt_first (cnt_first),
      .i_cnt_last  (cnt_last),
      .i_ctrl      (ctrl),
      .i_rs1_bit   (rs1_bit),
      .i_rs2_bit   (rs2_bit),
      .i_imm_bit   (imm_bit),
      .o_rsp       (o_rsp)
   );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
   output logic clk,
   output logic o_rst
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // held over the first two rising edges
   initial begin
      o_rst <= 1'b1;
      repeat (2) @(posedge clk);
      o_rst <= 1'b0;
   end

endmodule

// ==== bench/serial_exec_sva.sv ====
`timescale 1ns/1ps

module serial_exec_sva (
   input logic clk,
   input logic i_rst,
   input logic i_req,
   input logic i_ack,
   input logic i_cnt_en
);

   logic [6:0] run_len_q;   // cycles cnt_en has been high so far

   always_ff @(posedge clk) begin
      if (i_rst || !i_cnt_en) begin
         run_len_q <= '0;
      end else begin
         run_len_q <= run_len_q + 7'd1;
      end
   end

   ack_needs_req: assert property (@(posedge clk) disable iff (i_rst)
      $rose(i_ack) |-> $past(i_req))
      else $error("o_ack rose with no request pending");

   req_held: assert property (@(posedge clk) disable iff (i_rst)
      $fell(i_req) |-> i_ack)
      else $error("i_req dropped before o_ack was given");

   ack_release: assert property (@(posedge clk) disable iff (i_rst)
      (i_ack && !i_req) |=> !i_ack)
      else $error("o_ack did not fall one cycle after i_req went low");

   // one run is exactly 32 bit slots
   run_not_long: assert property (@(posedge clk) disable iff (i_rst)
      i_cnt_en |-> (run_len_q < 7'd32))
      else $error("cnt_en high for more than 32 cycles");

   run_exact: assert property (@(posedge clk) disable iff (i_rst)
      $fell(i_cnt_en) |-> (run_len_q == 7'd32))
      else $error("cnt_en run length was not 32 cycles");

endmodule

// ==== bench/tb_serial_exec.sv ====
`timescale 1ns/1ps

module tb_serial_exec;

   import serial_pkg::*;

   localparam int N_TXN   = 400;
   localparam int MAX_GAP = 3;
   localparam int LIMIT   = N_TXN * (36 + MAX_GAP) + 100;
   localparam int ACK_LAT = 33;   // edges from request sample to o_ack

   localparam logic [6:0] OP_REG = 7'b0110011;
   localparam logic [6:0] OP_IMM = 7'b0010011;
   localparam logic [6:0] OP_LUI = 7'b0110111;

   logic      clk;
   logic      rst;
   logic      req;
   exec_req_t req_data;
   logic      ack;
   exec_rsp_t rsp;

   integer seed;
   int     errors;
   int     cycle_cnt;

   clock_gen u_clk (
      .clk   (clk),
      .o_rst (rst)
   );

   serial_exec_top i_dut (
      .clk        (clk),
      .i_rst      (rst),
      .i_req      (req),
      .i_req_data (req_data),
      .o_ack      (ack),
      .o_rsp      (rsp)
   );

   bind serial_exec_top serial_exec_sva u_sva (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_req    (i_req),
      .i_ack    (o_ack),
      .i_cnt_en (cnt_en)
   );

   // RV32I reference for the supported subset
   function automatic exec_rsp_t expected_rsp(input exec_req_t rq);
      logic [6:0]  opc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] val;
      logic        ok;
      exec_rsp_t   r;
      opc = rq.instr[6:0];
      a   = rq.rs1;
      b   = (opc == OP_IMM) ? {{20{rq.instr[31]}}, rq.instr[31:20]} : rq.rs2;
      ok  = 1'b1;
      val = '0;
      case (rq.instr[14:12])
         3'b000:  val = (opc == OP_REG && rq.instr[30]) ? a - b : a + b;
         3'b010:  val = {31'b0, $signed(a) < $signed(b)};
         3'b011:  val = {31'b0, a < b};
         3'b100:  val = a ^ b;
         3'b110:  val = a | b;
         3'b111:  val = a & b;
         default: ok = 1'b0;   // shift encodings
      endcase
      if (opc == OP_LUI) begin
         val = {rq.instr[31:12], 12'b0};
         ok  = 1'b1;
      end else if (opc != OP_REG && opc != OP_IMM) begin
         ok = 1'b0;
      end
      r.rd_addr = rq.instr[11:7];
      r.rd_we   = ok && (rq.instr[11:7] != 5'd0);
      r.result  = r.rd_we ? val : '0;
      return r;
   endfunction

   task automatic make_request(output exec_req_t rq);
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] instr;
      logic [6:0]  opc;
      logic [2:0]  f3;
      logic [4:0]  rd;
      logic [11:0] imm;
      r0     = $random(seed);
      r1     = $random(seed);
      instr  = $random(seed);
      rq.rs1 = $random(seed);
      rq.rs2 = $random(seed);
      rd  = (r0[2:0] == 3'd0) ? 5'd0 : r0[7:3];   // rd zero about one time in eight
      f3  = r0[10:8];
      if (f3 == 3'b001 || f3 == 3'b101) begin
         f3 = 3'b000;
      end
      imm = instr[31:20];
      case (r0[13:11])
         3'd0, 3'd1, 3'd2: begin
            opc = OP_REG;
            instr[31:25] = (f3 == 3'b000 && r0[14]) ? 7'b0100000 : 7'b0000000;
            instr[14:12] = f3;
         end
         3'd3, 3'd4, 3'd5: begin
            opc = OP_IMM;
            instr[14:12] = f3;
         end
         3'd6: opc = OP_LUI;
         default: begin
            opc = r1[6:0];   // anything the unit does not handle
            if (opc == OP_REG || opc == OP_IMM || opc == OP_LUI) begin
               opc = 7'b1100011;
            end
         end
      endcase
      instr[11:7] = rd;
      instr[6:0]  = opc;
      case (r0[17:15])
         3'd0: begin   // equal operands
            if (opc == OP_IMM) rq.rs1 = {{20{imm[11]}}, imm};
            else rq.rs2 = rq.rs1;
         end
         3'd1: begin   // opposite signs
            if (opc == OP_IMM) rq.rs1[31] = ~imm[11];
            else rq.rs2[31] = ~rq.rs1[31];
         end
         3'd2: begin
            rq.rs1 = {28'b0, r1[11:8]};
            rq.rs2 = {28'b0, r1[15:12]};
         end
         default: ;
      endcase
      rq.instr = instr;
   endtask

   task automatic check_field(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      if (got !== exp) begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   // entered and left on a falling edge
   task automatic run_txn(input exec_req_t rq, input int hold, input int gap);
      exec_rsp_t exp;
      exec_rsp_t first;
      int        edges;
      exp      = expected_rsp(rq);
      req      = 1'b1;
      req_data = rq;
      edges    = 0;
      do begin
         @(negedge clk);
         edges++;
      end while (!ack && edges < 60);
      if (!ack) begin
         $display("o_ack never rose for instr %h at %0t", rq.instr, $time);
         errors++;
      end else begin
         check_field("o_ack latency", ACK_LAT, edges - 1);
         check_field("o_rsp.result", exp.result, rsp.result);
         check_field("o_rsp.rd_we", {31'b0, exp.rd_we}, {31'b0, rsp.rd_we});
         check_field("o_rsp.rd_addr", {27'b0, exp.rd_addr}, {27'b0, rsp.rd_addr});
         first = rsp;
         repeat (hold) begin
            @(negedge clk);   // requester holds off
            if (rsp !== first) begin
               $display("[FAIL] %0t o_rsp expected %h got %h", $time, first, rsp);
               errors++;
            end
            check_field("o_ack", 32'd1, {31'b0, ack});
         end
      end
      req = 1'b0;
      @(negedge clk);
      check_field("o_ack", 32'd0, {31'b0, ack});
      repeat (gap) @(negedge clk);
   endtask

   initial begin
      exec_req_t   rq;
      logic [31:0] r;
      int          hold;
      int          gap;
      seed     = 64;
      errors   = 0;
      req      = 1'b0;
      req_data = '0;
      @(negedge clk);
      while (rst !== 1'b0) @(negedge clk);
      check_field("o_ack", 32'd0, {31'b0, ack});
      check_field("o_rsp.result", 32'd0, rsp.result);
      check_field("o_rsp.rd_we", 32'd0, {31'b0, rsp.rd_we});
      check_field("o_rsp.rd_addr", 32'd0, {27'b0, rsp.rd_addr});
      for (int n = 0; n < N_TXN; n++) begin
         make_request(rq);
         r    = $random(seed);
         hold = r[0] ? 1 : 0;
         gap  = {30'b0, r[2:1]};
         run_txn(rq, hold, gap);
      end
      $display("%0d transactions, %0d errors", N_TXN, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // hang guard
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== tb.f ====
logic/serial_pkg.sv
logic/serial_decode.sv
logic/operand_shifter.sv
logic/serial_alu.sv
logic/serial_exec_top.sv
bench/clock_gen.sv
bench/serial_exec_sva.sv
bench/tb_serial_exec.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the serial exec testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_serial_exec -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_serial_exec)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
   exit 0
fi
echo "pass message not found"
exit 1
